/* verilog/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath widths
`define DATA_WIDTH    32
`define INST_WIDTH    32
`define REG_ADDR_BITS 5
`define IMM_WIDTH     16
`define SHAMT_BITS    5
`define OPCODE_BITS   6
`define FUNCT_BITS    6

// opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e

// funct codes, r-format only
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_SLT 6'h2a
`define FN_SLL 6'h00
`define FN_SRL 6'h02

`define ALU_OP_BITS 3
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_XOR 3'd4
`define ALU_SLT 3'd5
`define ALU_SLL 3'd6
`define ALU_SRL 3'd7

// one input credit per pipeline stage
`define PIPE_CREDITS 3
`define OUT_CREDITS  4

`endif

/* verilog/cpu_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

  typedef struct packed {
    logic [`OPCODE_BITS-1:0]   opcode;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`REG_ADDR_BITS-1:0] rd;
    logic [`SHAMT_BITS-1:0]    shamt;
    logic [`FUNCT_BITS-1:0]    funct;
  } r_fmt_t;

  typedef struct packed {
    logic [`OPCODE_BITS-1:0]   opcode;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`IMM_WIDTH-1:0]     imm;
  } i_fmt_t;

  // same instruction word, two field layouts
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

endpackage

`default_nettype wire

/* verilog/stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

// decoded instruction, decode register to execute
interface decode_if;
  logic                      valid;
  logic [`ALU_OP_BITS-1:0]   alu_op;
  logic [`REG_ADDR_BITS-1:0] rs;
  logic [`REG_ADDR_BITS-1:0] rt;
  logic [`REG_ADDR_BITS-1:0] dest;
  logic                      write;
  logic                      use_imm;
  logic [`IMM_WIDTH-1:0]     imm;
  logic [`SHAMT_BITS-1:0]    shamt;
  logic                      take;

  modport source (output valid, alu_op, rs, rt, dest, write, use_imm, imm, shamt,
                  input take);
  modport sink (input valid, alu_op, rs, rt, dest, write, use_imm, imm, shamt,
                output take);
endinterface

// alu result, execute register to result register
interface exec_if;
  logic                      valid;
  logic                      write;
  logic [`REG_ADDR_BITS-1:0] dest;
  logic [`DATA_WIDTH-1:0]    data;
  logic                      take;

  modport source (output valid, write, dest, data, input take);
  modport sink (input valid, write, dest, data, output take);
endinterface

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module register_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_write,
  input  logic [`REG_ADDR_BITS-1:0] wb_addr,
  input  logic [`DATA_WIDTH-1:0]    wb_data,
  input  logic [`REG_ADDR_BITS-1:0] read_addr_a,
  output logic [`DATA_WIDTH-1:0]    read_data_a,
  input  logic [`REG_ADDR_BITS-1:0] read_addr_b,
  output logic [`DATA_WIDTH-1:0]    read_data_b
);

  localparam int NUM_REGS = 1 << `REG_ADDR_BITS;

  logic [`DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NUM_REGS; k++)
        regs[k] <= '0;
    end else if (wb_write && wb_addr != '0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // r0 is hardwired to zero
  assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
  assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inst_valid,
  input  logic [`INST_WIDTH-1:0] inst,
  decode_if.source               dec
);

  instr_u                    word;
  logic [`ALU_OP_BITS-1:0]   alu_op_d;
  logic [`REG_ADDR_BITS-1:0] dest_d;
  logic                      use_imm_d;
  logic                      known;
  logic                      write_d;

  assign word = inst;

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op_d  = `ALU_ADD;
    use_imm_d = 1'b0;
    known     = 1'b1;
    dest_d    = word.r_fmt.rd;
    if (word.r_fmt.opcode == `OP_RTYPE) begin
      case (word.r_fmt.funct)
        `FN_ADD: alu_op_d = `ALU_ADD;
        `FN_SUB: alu_op_d = `ALU_SUB;
        `FN_AND: alu_op_d = `ALU_AND;
        `FN_OR:  alu_op_d = `ALU_OR;
        `FN_XOR: alu_op_d = `ALU_XOR;
        `FN_SLT: alu_op_d = `ALU_SLT;
        `FN_SLL: alu_op_d = `ALU_SLL;
        `FN_SRL: alu_op_d = `ALU_SRL;
        default: known = 1'b0;
      endcase
    end else begin
      // immediate forms write rt
      dest_d    = word.i_fmt.rt;
      use_imm_d = 1'b1;
      case (word.i_fmt.opcode)
        `OP_ADDI: alu_op_d = `ALU_ADD;
        `OP_ANDI: alu_op_d = `ALU_AND;
        `OP_ORI:  alu_op_d = `ALU_OR;
        `OP_XORI: alu_op_d = `ALU_XOR;
        default:  known = 1'b0;
      endcase
    end
    write_d = known && (dest_d != '0);
  end

  ////////////////////////////////////////////////////////////
  // decode register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid   <= 1'b0;
      dec.alu_op  <= '0;
      dec.rs      <= '0;
      dec.rt      <= '0;
      dec.dest    <= '0;
      dec.write   <= 1'b0;
      dec.use_imm <= 1'b0;
      dec.imm     <= '0;
      dec.shamt   <= '0;
    end else if (inst_valid) begin
      // credits guarantee the slot is free here
      dec.valid   <= 1'b1;
      dec.alu_op  <= alu_op_d;
      dec.rs      <= word.r_fmt.rs;
      dec.rt      <= word.r_fmt.rt;
      dec.dest    <= dest_d;
      dec.write   <= write_d;
      dec.use_imm <= use_imm_d;
      dec.imm     <= word.i_fmt.imm;
      dec.shamt   <= word.r_fmt.shamt;
    end else if (dec.take) begin
      dec.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execute_stage (
  input  logic                      clk,
  input  logic                      rst,
  decode_if.sink                    dec,
  exec_if.source                    exe,
  output logic [`REG_ADDR_BITS-1:0] read_addr_a,
  input  logic [`DATA_WIDTH-1:0]    read_data_a,
  output logic [`REG_ADDR_BITS-1:0] read_addr_b,
  input  logic [`DATA_WIDTH-1:0]    read_data_b,
  input  logic                      held_write,
  input  logic [`REG_ADDR_BITS-1:0] held_addr,
  input  logic [`DATA_WIDTH-1:0]    held_data
);

  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] rt_val;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] alu_y;

  // youngest writer wins: execute reg, then held result, then regfile
  function automatic logic [`DATA_WIDTH-1:0] pick(
    input logic [`REG_ADDR_BITS-1:0] addr,
    input logic [`DATA_WIDTH-1:0]    rf_data
  );
    logic [`DATA_WIDTH-1:0] value;
    if (exe.valid && exe.write && exe.dest == addr)
      value = exe.data;
    else if (held_write && held_addr == addr)
      value = held_data;
    else
      value = rf_data;
    return value;
  endfunction

  assign read_addr_a = dec.rs;
  assign read_addr_b = dec.rt;

  // move when empty or when our item leaves
  assign dec.take = !exe.valid || exe.take;

  ////////////////////////////////////////////////////////////
  // operands and alu
  ////////////////////////////////////////////////////////////

  always_comb begin
    op_a   = pick(dec.rs, read_data_a);
    rt_val = pick(dec.rt, read_data_b);
    // immediates are zero extended
    op_b = dec.use_imm ? {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, dec.imm} : rt_val;
    case (dec.alu_op)
      `ALU_ADD: alu_y = op_a + op_b;
      `ALU_SUB: alu_y = op_a - op_b;
      `ALU_AND: alu_y = op_a & op_b;
      `ALU_OR:  alu_y = op_a | op_b;
      `ALU_XOR: alu_y = op_a ^ op_b;
      `ALU_SLT: alu_y = {{(`DATA_WIDTH - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      `ALU_SLL: alu_y = op_b << dec.shamt;
      `ALU_SRL: alu_y = op_b >> dec.shamt;
      default:  alu_y = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // execute register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      exe.valid <= 1'b0;
      exe.write <= 1'b0;
      exe.dest  <= '0;
      exe.data  <= '0;
    end else if (dec.take) begin
      exe.valid <= dec.valid;
      exe.write <= dec.write;
      exe.dest  <= dec.dest;
      exe.data  <= alu_y;
    end
  end

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module result_stage (
  input  logic                      clk,
  input  logic                      rst,
  exec_if.sink                      exe,
  input  logic                      result_credit,
  output logic                      result_valid,
  output logic                      result_write,
  output logic [`REG_ADDR_BITS-1:0] result_addr,
  output logic [`DATA_WIDTH-1:0]    result_data,
  output logic                      inst_credit,
  output logic                      held_write,
  output logic [`REG_ADDR_BITS-1:0] held_addr,
  output logic [`DATA_WIDTH-1:0]    held_data,
  output logic                      wb_write,
  output logic [`REG_ADDR_BITS-1:0] wb_addr,
  output logic [`DATA_WIDTH-1:0]    wb_data
);

  localparam int CREDIT_BITS = $clog2(`OUT_CREDITS + 1);

  logic                      full;
  logic                      write_q;
  logic [`REG_ADDR_BITS-1:0] dest_q;
  logic [`DATA_WIDTH-1:0]    data_q;
  logic [CREDIT_BITS-1:0]    credits;
  logic                      emit;

  assign emit     = full && (credits != '0);
  assign exe.take = !full || emit;

  always_ff @(posedge clk) begin
    if (rst) begin
      full    <= 1'b0;
      write_q <= 1'b0;
      dest_q  <= '0;
      data_q  <= '0;
    end else if (exe.take) begin
      full    <= exe.valid;
      write_q <= exe.write;
      dest_q  <= exe.dest;
      data_q  <= exe.data;
    end
  end

  // output credit counter
  always_ff @(posedge clk) begin
    if (rst) begin
      credits     <= CREDIT_BITS'(`OUT_CREDITS);
      inst_credit <= 1'b0;
    end else begin
      inst_credit <= emit;
      case ({emit, result_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign result_valid = emit;
  assign result_write = write_q;
  assign result_addr  = dest_q;
  assign result_data  = data_q;

  // pending result, seen by execute forwarding
  assign held_write = full && write_q;
  assign held_addr  = dest_q;
  assign held_data  = data_q;

  assign wb_write = emit && write_q;
  assign wb_addr  = dest_q;
  assign wb_data  = data_q;

endmodule

`default_nettype wire

/* verilog/processor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module processor (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_valid,
  input  logic [`INST_WIDTH-1:0]    inst,
  output logic                      inst_credit,
  output logic                      result_valid,
  output logic                      result_write,
  output logic [`REG_ADDR_BITS-1:0] result_addr,
  output logic [`DATA_WIDTH-1:0]    result_data,
  input  logic                      result_credit
);

  logic [`REG_ADDR_BITS-1:0] read_addr_a;
  logic [`DATA_WIDTH-1:0]    read_data_a;
  logic [`REG_ADDR_BITS-1:0] read_addr_b;
  logic [`DATA_WIDTH-1:0]    read_data_b;
  logic                      held_write;
  logic [`REG_ADDR_BITS-1:0] held_addr;
  logic [`DATA_WIDTH-1:0]    held_data;
  logic                      wb_write;
  logic [`REG_ADDR_BITS-1:0] wb_addr;
  logic [`DATA_WIDTH-1:0]    wb_data;

  decode_if dec_bus ();
  exec_if   exe_bus ();

  ////////////////////////////////////////////////////////////
  // pipeline
  ////////////////////////////////////////////////////////////

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .dec        (dec_bus.source)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec_bus.sink),
    .exe         (exe_bus.source),
    .read_addr_a (read_addr_a),
    .read_data_a (read_data_a),
    .read_addr_b (read_addr_b),
    .read_data_b (read_data_b),
    .held_write  (held_write),
    .held_addr   (held_addr),
    .held_data   (held_data)
  );

  result_stage u_result (
    .clk           (clk),
    .rst           (rst),
    .exe           (exe_bus.sink),
    .result_credit (result_credit),
    .result_valid  (result_valid),
    .result_write  (result_write),
    .result_addr   (result_addr),
    .result_data   (result_data),
    .inst_credit   (inst_credit),
    .held_write    (held_write),
    .held_addr     (held_addr),
    .held_data     (held_data),
    .wb_write      (wb_write),
    .wb_addr       (wb_addr),
    .wb_data       (wb_data)
  );

  register_file u_regfile (
    .clk         (clk),
    .rst         (rst),
    .wb_write    (wb_write),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .read_addr_a (read_addr_a),
    .read_data_a (read_data_a),
    .read_addr_b (read_addr_b),
    .read_data_b (read_data_b)
  );

endmodule

`default_nettype wire

/* tb/tb_processor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_processor import cpu_pkg::*; ;

  localparam int NUM_INSTS   = 200;
  localparam int CYCLE_NS    = 20;
  localparam int WATCHDOG_NS = NUM_INSTS * 40 * CYCLE_NS;
  localparam logic [31:0] SEED = 32'hb5f8;

  logic                      clk;
  logic                      rst;
  logic                      inst_valid;
  logic [`INST_WIDTH-1:0]    inst;
  logic                      inst_credit;
  logic                      result_valid;
  logic                      result_write;
  logic [`REG_ADDR_BITS-1:0] result_addr;
  logic [`DATA_WIDTH-1:0]    result_data;
  logic                      result_credit;

  logic [31:0]            lfsr;
  logic [`DATA_WIDTH-1:0] model_regs [32];
  instr_u                 sent_q [$];
  instr_u                 directed [$];
  int errors;
  int checked;
  int sent;
  int emitted;
  int pending;
  int in_credits;
  int ic_pulses;

  processor uut (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .inst_credit   (inst_credit),
    .result_valid  (result_valid),
    .result_write  (result_write),
    .result_addr   (result_addr),
    .result_data   (result_data),
    .result_credit (result_credit)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  function automatic instr_u r_inst(input logic [5:0] fn, input int rs, input int rt,
                                    input int rd, input int shamt);
    instr_u w;
    w.r_fmt = '{`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    return w;
  endfunction

  function automatic instr_u i_inst(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
    instr_u w;
    w.i_fmt = '{op, 5'(rs), 5'(rt), imm};
    return w;
  endfunction

  // only r0..r7 so that dependencies are frequent
  function automatic instr_u random_inst();
    instr_u     w;
    logic [3:0] sel;
    sel = 4'(take_bits(4));
    w = '0;
    w.r_fmt.rs = 5'(take_bits(3));
    w.r_fmt.rt = 5'(take_bits(3));
    if (sel < 4'd8 || sel >= 4'd14) begin
      w.r_fmt.rd    = 5'(take_bits(3));
      w.r_fmt.shamt = 5'(take_bits(5));
      case (sel)
        4'd0:    w.r_fmt.funct = `FN_ADD;
        4'd1:    w.r_fmt.funct = `FN_SUB;
        4'd2:    w.r_fmt.funct = `FN_AND;
        4'd3:    w.r_fmt.funct = `FN_OR;
        4'd4:    w.r_fmt.funct = `FN_XOR;
        4'd5:    w.r_fmt.funct = `FN_SLT;
        4'd6:    w.r_fmt.funct = `FN_SLL;
        4'd7:    w.r_fmt.funct = `FN_SRL;
        default: w.r_fmt.funct = 6'(take_bits(6));
      endcase
    end else begin
      w.i_fmt.imm = 16'(take_bits(16));
      case (sel)
        4'd8:    w.i_fmt.opcode = `OP_ADDI;
        4'd9:    w.i_fmt.opcode = `OP_ANDI;
        4'd10:   w.i_fmt.opcode = `OP_ORI;
        4'd11:   w.i_fmt.opcode = `OP_XORI;
        default: w.i_fmt.opcode = 6'(take_bits(6));
      endcase
    end
    return w;
  endfunction

  // sequential model that tells whether the encoding is known
  function automatic logic model_step(input instr_u w, output logic exp_write,
                                      output logic [4:0] exp_addr,
                                      output logic [31:0] exp_data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_z;
    logic        known;
    a     = model_regs[w.r_fmt.rs];
    b     = model_regs[w.r_fmt.rt];
    imm_z = {16'h0000, w.i_fmt.imm};
    known = 1'b1;
    exp_data = '0;
    if (w.r_fmt.opcode == `OP_RTYPE) begin
      exp_addr = w.r_fmt.rd;
      case (w.r_fmt.funct)
        `FN_ADD: exp_data = a + b;
        `FN_SUB: exp_data = a - b;
        `FN_AND: exp_data = a & b;
        `FN_OR:  exp_data = a | b;
        `FN_XOR: exp_data = a ^ b;
        `FN_SLT: exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `FN_SLL: exp_data = b << w.r_fmt.shamt;
        `FN_SRL: exp_data = b >> w.r_fmt.shamt;
        default: known = 1'b0;
      endcase
    end else begin
      exp_addr = w.i_fmt.rt;
      case (w.i_fmt.opcode)
        `OP_ADDI: exp_data = a + imm_z;
        `OP_ANDI: exp_data = a & imm_z;
        `OP_ORI:  exp_data = a | imm_z;
        `OP_XORI: exp_data = a ^ imm_z;
        default:  known = 1'b0;
      endcase
    end
    exp_write = known && (exp_addr != 5'd0);
    if (exp_write)
      model_regs[exp_addr] = exp_data;
    return known;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_counts();
    $display("checked %0d results, sent %0d, inst_credit pulses %0d, errors %0d",
             checked, sent, ic_pulses, errors);
  endtask

  ////////////////////////////////////////////////////////////
  // result checking
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    instr_u      w;
    logic        known;
    logic        exp_write;
    logic [4:0]  exp_addr;
    logic [31:0] exp_data;
    if (!rst && result_valid) begin
      if (sent_q.size() == 0) begin
        $display("error: result emitted with no instruction outstanding");
        errors++;
      end else begin
        w = sent_q.pop_front();
        known = model_step(w, exp_write, exp_addr, exp_data);
        compare($sformatf("inst %0d result_write", checked), exp_write, result_write);
        if (known)
          compare($sformatf("inst %0d result_addr", checked), exp_addr, result_addr);
        if (exp_write)
          compare($sformatf("inst %0d result_data", checked), exp_data, result_data);
        checked++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("error: run did not complete within %0d ns", WATCHDOG_NS);
    errors++;
    report_counts();
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    instr_u w;
    clk           = 1'b0;
    rst           = 1'b1;
    inst_valid    = 1'b0;
    inst          = '0;
    result_credit = 1'b0;
    lfsr          = SEED;
    errors = 0;
    checked = 0;
    sent = 0;
    emitted = 0;
    pending = 0;
    ic_pulses = 0;
    in_credits = `PIPE_CREDITS;
    for (int k = 0; k < 32; k++)
      model_regs[k] = '0;

    // first reads see an all-zero register file
    directed.push_back(r_inst(`FN_ADD, 2, 3, 1, 0));
    directed.push_back(i_inst(`OP_ADDI, 0, 1, 16'h8001));
    directed.push_back(i_inst(`OP_ORI, 1, 2, 16'hf0f0));
    directed.push_back(r_inst(`FN_ADD, 1, 2, 3, 0));
    directed.push_back(r_inst(`FN_SUB, 0, 3, 4, 0));
    directed.push_back(r_inst(`FN_SLT, 4, 1, 5, 0));
    directed.push_back(r_inst(`FN_SLL, 0, 4, 6, 7));
    directed.push_back(r_inst(`FN_SRL, 0, 4, 7, 3));
    directed.push_back(i_inst(`OP_XORI, 7, 6, 16'hffff));
    directed.push_back(r_inst(`FN_ADD, 1, 2, 0, 0));
    directed.push_back(r_inst(`FN_OR, 0, 0, 5, 0));
    directed.push_back(r_inst(6'h3f, 1, 2, 6, 0));
    directed.push_back(i_inst(6'h23, 1, 7, 16'h0004));
    directed.push_back(r_inst(`FN_XOR, 6, 7, 3, 0));

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // idle pipeline after reset
    repeat (4) begin
      @(posedge clk);
      compare("idle result_valid", 1'b0, result_valid);
      compare("idle inst_credit", 1'b0, inst_credit);
    end

    while (!(sent == NUM_INSTS && emitted == NUM_INSTS && pending == 0)) begin
      @(posedge clk);
      if (inst_valid)
        in_credits--;
      if (inst_credit) begin
        in_credits++;
        ic_pulses++;
      end
      if (result_valid) begin
        pending++;
        emitted++;
      end
      if (result_credit)
        pending--;
      if (pending > `OUT_CREDITS) begin
        $display("error: %0d results outstanding, more than the output credits", pending);
        errors++;
      end

      if (sent < NUM_INSTS && in_credits > 0 && take_bits(2) != 0) begin
        w = (sent < directed.size()) ? directed[sent] : random_inst();
        sent_q.push_back(w);
        sent++;
        inst_valid <= 1'b1;
        inst       <= w;
      end else begin
        inst_valid <= 1'b0;
      end

      // consumer frees slots at random
      result_credit <= (pending > 0) && take_bits(1) != 0;
    end

    compare("inst_credit pulses", sent, ic_pulses);
    report_counts();
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/stage_if.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/processor.sv
tb/tb_processor.sv

/* Bender.yml */
package:
  name: processor

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/stage_if.sv
      - verilog/register_file.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/result_stage.sv
      - verilog/processor.sv
  - target: simulation
    files:
      - tb/tb_processor.sv
